// ==== Makefile ====
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP ?= fetch_unit_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/fetch_pc_stage.sv ====
`timescale 1ns/10ps

module fetch_pc_stage #(
	parameter int FETCH_SIZE = 2,
	parameter int TAG_WIDTH = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,

	input  logic fetch_valid_i,
	input  logic [31:0] fetch_pc_i,
	input  logic [FETCH_SIZE-1:0] fetch_mask_i,
	input  logic [TAG_WIDTH-1:0] fetch_tag_i,
	output logic fetch_ready_o,

	output logic s1_valid_o,
	output logic [31:0] s1_pc_o,
	output logic [FETCH_SIZE-1:0] s1_mask_o,
	output logic [TAG_WIDTH-1:0] s1_tag_o,
	input  logic s2_ready_i
);

	// low for the first cycle out of reset
	logic running;
	logic s1_valid;
	logic [31:0] s1_pc;
	logic [FETCH_SIZE-1:0] s1_mask;
	logic [TAG_WIDTH-1:0] s1_tag;
	logic take;
	logic drain;

	// group moves into the word reader
	assign drain = s1_valid & s2_ready_i;

	// empty or draining, never on a flush edge
	assign fetch_ready_o = running & ~flush_i & (~s1_valid | s2_ready_i);
	assign take = fetch_valid_i & fetch_ready_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else if (flush_i) begin
			s1_valid <= 1'b0;
		end else if (take) begin
			s1_valid <= 1'b1;
		end else if (drain) begin
			s1_valid <= 1'b0;
		end
	end

	// payload only moves on a take, so it holds under stall
	always_ff @(posedge clk) begin
		if (take) begin
			s1_pc <= fetch_pc_i;
			s1_mask <= fetch_mask_i;
			s1_tag <= fetch_tag_i;
		end
	end

	assign s1_valid_o = s1_valid;
	assign s1_pc_o = s1_pc;
	assign s1_mask_o = s1_mask;
	assign s1_tag_o = s1_tag;

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

	// R-format view of one instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} inst_r_t;

	// I-format view of the same word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} inst_i_t;

	// one word, decoded either way
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_word_u;

	// instruction classes, sorted by opcode range
	typedef enum logic [2:0] {
		// opcode 0
		CLASS_ALU_REG = 3'd0,
		// opcodes 8 to 15
		CLASS_ALU_IMM = 3'd1,
		// opcodes 32 to 37
		CLASS_LOAD    = 3'd2,
		// opcodes 40 to 43
		CLASS_STORE   = 3'd3,
		// opcodes 1 and 4 to 7
		CLASS_BRANCH  = 3'd4,
		CLASS_OTHER   = 3'd5
	} inst_class_e;

	// decode result per lane, 54 bits
	typedef struct packed {
		inst_class_e inst_class;
		// rs
		logic [4:0] src_a;
		// rt
		logic [4:0] src_b;
		logic [4:0] dest;
		logic has_dest;
		// sign-extended, zero for register ALU ops
		logic [31:0] imm;
		logic is_ctrl;
		logic [1:0] reserved;
	} decode_info_t;

endpackage

// ==== design/fetch_unit_top.sv ====
`timescale 1ns/10ps

module fetch_unit_top #(
	parameter int FETCH_SIZE = 2,
	parameter int TAG_WIDTH = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,

	input  logic fetch_valid_i,
	input  logic [31:0] fetch_pc_i,
	input  logic [FETCH_SIZE-1:0] fetch_mask_i,
	input  logic [TAG_WIDTH-1:0] fetch_tag_i,
	output logic fetch_ready_o,

	output logic out_valid_o,
	output logic [31:0] out_pc_o,
	output logic [FETCH_SIZE-1:0] out_mask_o,
	output logic [TAG_WIDTH-1:0] out_tag_o,
	output fetch_pkg::decode_info_t [FETCH_SIZE-1:0] out_decode_o,
	input  logic out_ready_i,

	output logic bus_req_valid_o,
	output logic [31:0] bus_req_addr_o,
	input  logic bus_req_ready_i,
	input  logic bus_resp_valid_i,
	input  logic [31:0] bus_resp_data_i
);

	// pc stage to word reader
	logic s1_valid;
	logic [31:0] s1_pc;
	logic [FETCH_SIZE-1:0] s1_mask;
	logic [TAG_WIDTH-1:0] s1_tag;
	logic s2_ready;

	fetch_pc_stage #(
		.FETCH_SIZE (FETCH_SIZE),
		.TAG_WIDTH  (TAG_WIDTH)
	) u_pc_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_pc_i    (fetch_pc_i),
		.fetch_mask_i  (fetch_mask_i),
		.fetch_tag_i   (fetch_tag_i),
		.fetch_ready_o (fetch_ready_o),
		.s1_valid_o    (s1_valid),
		.s1_pc_o       (s1_pc),
		.s1_mask_o     (s1_mask),
		.s1_tag_o      (s1_tag),
		.s2_ready_i    (s2_ready)
	);

	fetch_word_reader #(
		.FETCH_SIZE (FETCH_SIZE),
		.TAG_WIDTH  (TAG_WIDTH)
	) u_word_reader (
		.clk              (clk),
		.rst_n            (rst_n),
		.flush_i          (flush_i),
		.s1_valid_i       (s1_valid),
		.s1_pc_i          (s1_pc),
		.s1_mask_i        (s1_mask),
		.s1_tag_i         (s1_tag),
		.s2_ready_o       (s2_ready),
		.bus_req_valid_o  (bus_req_valid_o),
		.bus_req_addr_o   (bus_req_addr_o),
		.bus_req_ready_i  (bus_req_ready_i),
		.bus_resp_valid_i (bus_resp_valid_i),
		.bus_resp_data_i  (bus_resp_data_i),
		.out_valid_o      (out_valid_o),
		.out_pc_o         (out_pc_o),
		.out_mask_o       (out_mask_o),
		.out_tag_o        (out_tag_o),
		.out_decode_o     (out_decode_o),
		.out_ready_i      (out_ready_i)
	);

endmodule

// ==== design/fetch_word_reader.sv ====
`timescale 1ns/10ps

module fetch_word_reader #(
	parameter int FETCH_SIZE = 2,
	parameter int TAG_WIDTH = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,

	input  logic s1_valid_i,
	input  logic [31:0] s1_pc_i,
	input  logic [FETCH_SIZE-1:0] s1_mask_i,
	input  logic [TAG_WIDTH-1:0] s1_tag_i,
	output logic s2_ready_o,

	output logic bus_req_valid_o,
	output logic [31:0] bus_req_addr_o,
	input  logic bus_req_ready_i,
	input  logic bus_resp_valid_i,
	input  logic [31:0] bus_resp_data_i,

	output logic out_valid_o,
	output logic [31:0] out_pc_o,
	output logic [FETCH_SIZE-1:0] out_mask_o,
	output logic [TAG_WIDTH-1:0] out_tag_o,
	output fetch_pkg::decode_info_t [FETCH_SIZE-1:0] out_decode_o,
	input  logic out_ready_i
);

	localparam int LANE_W = (FETCH_SIZE > 1) ? $clog2(FETCH_SIZE) : 1;
	// clears lane and byte bits of the pc
	localparam logic [31:0] BASE_MASK = ~((32'(FETCH_SIZE) << 2) - 32'd1);

	// one-hot bus states
	localparam logic [2:0] ST_IDLE = 3'b001;
	localparam logic [2:0] ST_REQ  = 3'b010;
	localparam logic [2:0] ST_WAIT = 3'b100;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic held;
	logic [31:0] s2_pc;
	logic [FETCH_SIZE-1:0] s2_mask;
	logic [TAG_WIDTH-1:0] s2_tag;
	logic [FETCH_SIZE-1:0] need;
	logic [LANE_W-1:0] lane;
	fetch_pkg::decode_info_t [FETCH_SIZE-1:0] dec_q;
	fetch_pkg::decode_info_t resp_decode;
	logic out_fire;
	logic load;
	logic resp_take;

	assign out_valid_o = held & ~|need & ~flush_i;
	assign out_fire = out_valid_o & out_ready_i;
	assign s2_ready_o = (state == ST_IDLE) & (~held | out_fire);
	assign load = s1_valid_i & s2_ready_o & ~flush_i;

	// lowest lane still needed
	always_comb begin
		lane = '0;
		for (int k = FETCH_SIZE - 1; k >= 0; k--) begin
			if (need[k]) begin
				lane = LANE_W'(k);
			end
		end
	end

	assign bus_req_valid_o = (state == ST_REQ);
	assign bus_req_addr_o = (s2_pc & BASE_MASK) | (32'(lane) << 2);

	// a response after a flush finds its need bit gone and is dropped
	assign resp_take = (state == ST_WAIT) & bus_resp_valid_i & need[lane] & ~flush_i;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (|need && !flush_i) begin
					state_nxt = ST_REQ;
				end
			end
			ST_REQ: begin
				// accepted reads complete even when flushed
				if (bus_req_ready_i) begin
					state_nxt = ST_WAIT;
				end else if (flush_i) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_WAIT: begin
				if (bus_resp_valid_i) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			held <= 1'b0;
			need <= '0;
		end else begin
			state <= state_nxt;
			if (flush_i) begin
				held <= 1'b0;
				need <= '0;
			end else if (load) begin
				held <= 1'b1;
				need <= s1_mask_i;
			end else begin
				if (out_fire) begin
					held <= 1'b0;
				end
				if (resp_take) begin
					need[lane] <= 1'b0;
				end
			end
		end
	end

	// unwanted lanes stay zero from the load
	always_ff @(posedge clk) begin
		if (load) begin
			s2_pc <= s1_pc_i;
			s2_mask <= s1_mask_i;
			s2_tag <= s1_tag_i;
			dec_q <= '0;
		end else if (resp_take) begin
			dec_q[lane] <= resp_decode;
		end
	end

	inst_decoder u_decoder (
		.inst_i   (bus_resp_data_i),
		.decode_o (resp_decode)
	);

	assign out_pc_o = s2_pc;
	assign out_mask_o = s2_mask;
	assign out_tag_o = s2_tag;
	assign out_decode_o = dec_q;

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
	input  logic [31:0] inst_i,
	output fetch_pkg::decode_info_t decode_o
);

	fetch_pkg::inst_word_u word;
	fetch_pkg::inst_class_e cls;
	logic [5:0] opcode;
	logic [4:0] dest;
	logic writes_reg;
	logic [31:0] imm_sext;

	assign word = inst_i;
	// opcode sits in the same bits in both views
	assign opcode = word.r.opcode;

	always_comb begin
		case (opcode)
			6'd0: begin
				cls = fetch_pkg::CLASS_ALU_REG;
			end
			6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15: begin
				cls = fetch_pkg::CLASS_ALU_IMM;
			end
			6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37: begin
				cls = fetch_pkg::CLASS_LOAD;
			end
			6'd40, 6'd41, 6'd42, 6'd43: begin
				cls = fetch_pkg::CLASS_STORE;
			end
			6'd1, 6'd4, 6'd5, 6'd6, 6'd7: begin
				cls = fetch_pkg::CLASS_BRANCH;
			end
			default: begin
				cls = fetch_pkg::CLASS_OTHER;
			end
		endcase
	end

	// destination register by class
	always_comb begin
		case (cls)
			fetch_pkg::CLASS_ALU_REG: begin
				dest = word.r.rd;
				writes_reg = 1'b1;
			end
			fetch_pkg::CLASS_ALU_IMM, fetch_pkg::CLASS_LOAD: begin
				dest = word.i.rt;
				writes_reg = 1'b1;
			end
			default: begin
				dest = 5'd0;
				writes_reg = 1'b0;
			end
		endcase
	end

	// register ALU words have no immediate
	assign imm_sext = (cls == fetch_pkg::CLASS_ALU_REG) ? 32'd0 :
		{{16{word.i.imm[15]}}, word.i.imm};

	always_comb begin
		decode_o.inst_class = cls;
		decode_o.src_a = word.i.rs;
		decode_o.src_b = word.i.rt;
		decode_o.dest = dest;
		// writes to r0 are dropped
		decode_o.has_dest = writes_reg & (dest != 5'd0);
		decode_o.imm = imm_sext;
		decode_o.is_ctrl = (cls == fetch_pkg::CLASS_BRANCH);
		decode_o.reserved = 2'b00;
	end

endmodule

// ==== files.f ====
design/fetch_pkg.sv
design/inst_decoder.sv
design/fetch_pc_stage.sv
design/fetch_word_reader.sv
design/fetch_unit_top.sv
sim/fetch_unit_chk.sv
sim/fetch_unit_tb.sv

// ==== sim/fetch_unit_chk.sv ====
`timescale 1ns/10ps

module fetch_unit_chk #(
	parameter int FETCH_SIZE = 2,
	parameter int TAG_WIDTH = 16
) (
	input logic clk,
	input logic rst_n,
	input logic flush_i,
	input logic req_valid_i,
	input logic [31:0] req_addr_i,
	input logic req_ready_i,
	input logic resp_valid_i,
	input logic out_valid_i,
	input logic out_ready_i,
	input logic [31:0] out_pc_i,
	input logic [FETCH_SIZE-1:0] out_mask_i,
	input logic [TAG_WIDTH-1:0] out_tag_i,
	input fetch_pkg::decode_info_t [FETCH_SIZE-1:0] out_decode_i
);

	// a read accepted and not yet answered
	logic outstanding;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
		end else if (req_valid_i && req_ready_i) begin
			outstanding <= 1'b1;
		end else if (resp_valid_i) begin
			outstanding <= 1'b0;
		end
	end

	// only a flush may withdraw a waiting request
	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid_i && !req_ready_i && !flush_i |=> req_valid_i && $stable(req_addr_i))
		else $error("bus request dropped or changed before acceptance");

	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_i && !out_ready_i |=> (out_valid_i || flush_i) && $stable(out_pc_i) &&
		$stable(out_mask_i) && $stable(out_tag_i) && $stable(out_decode_i))
		else $error("decoded output changed while stalled");

	one_read: assert property (@(posedge clk) disable iff (!rst_n)
		outstanding |-> !req_valid_i)
		else $error("bus request raised while a read is outstanding");

endmodule

// ==== sim/fetch_unit_tb.sv ====
`timescale 1ns/10ps

module fetch_unit_tb;

	localparam int FETCH_SIZE = 2;
	localparam int TAG_WIDTH = 16;
	localparam int NUM_GROUPS = 300;
	localparam int CYCLE_LIMIT = NUM_GROUPS * (FETCH_SIZE * 6 + 4) + 200;
	// bytes covered by one fetch group
	localparam int GROUP_BYTES = 4 * FETCH_SIZE;

	logic clk;
	logic rst_n;
	logic flush;
	logic fetch_valid;
	logic [31:0] fetch_pc;
	logic [FETCH_SIZE-1:0] fetch_mask;
	logic [TAG_WIDTH-1:0] fetch_tag;
	logic fetch_ready;
	logic out_valid;
	logic [31:0] out_pc;
	logic [FETCH_SIZE-1:0] out_mask;
	logic [TAG_WIDTH-1:0] out_tag;
	fetch_pkg::decode_info_t [FETCH_SIZE-1:0] out_decode;
	logic out_ready;
	logic bus_req_valid;
	logic [31:0] bus_req_addr;
	logic bus_req_ready;
	logic bus_resp_valid;
	logic [31:0] bus_resp_data;

	integer seed;
	logic [31:0] mem [0:255];

	// groups in flight, oldest first
	logic [31:0] exp_pc_q[$];
	logic [FETCH_SIZE-1:0] exp_mask_q[$];
	logic [TAG_WIDTH-1:0] exp_tag_q[$];
	logic [31:0] exp_addr_q[$];

	// monitor side
	int taken;
	int accept_count;
	int resp_count;
	logic [31:0] resp_addr;
	int cycles;
	int errors;
	int checked;
	int flushed;

	// driver side
	int taken_seen;
	int accept_seen;
	int resp_wait;
	int stall_left;
	int tag_seq;

	fetch_unit_top #(
		.FETCH_SIZE (FETCH_SIZE),
		.TAG_WIDTH  (TAG_WIDTH)
	) fetch_unit_top_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.flush_i          (flush),
		.fetch_valid_i    (fetch_valid),
		.fetch_pc_i       (fetch_pc),
		.fetch_mask_i     (fetch_mask),
		.fetch_tag_i      (fetch_tag),
		.fetch_ready_o    (fetch_ready),
		.out_valid_o      (out_valid),
		.out_pc_o         (out_pc),
		.out_mask_o       (out_mask),
		.out_tag_o        (out_tag),
		.out_decode_o     (out_decode),
		.out_ready_i      (out_ready),
		.bus_req_valid_o  (bus_req_valid),
		.bus_req_addr_o   (bus_req_addr),
		.bus_req_ready_i  (bus_req_ready),
		.bus_resp_valid_i (bus_resp_valid),
		.bus_resp_data_i  (bus_resp_data)
	);

	bind fetch_unit_top fetch_unit_chk #(
		.FETCH_SIZE (FETCH_SIZE),
		.TAG_WIDTH  (TAG_WIDTH)
	) fetch_unit_chk_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_i      (flush_i),
		.req_valid_i  (bus_req_valid_o),
		.req_addr_i   (bus_req_addr_o),
		.req_ready_i  (bus_req_ready_i),
		.resp_valid_i (bus_resp_valid_i),
		.out_valid_i  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_pc_i     (out_pc_o),
		.out_mask_i   (out_mask_o),
		.out_tag_i    (out_tag_o),
		.out_decode_i (out_decode_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[30:0]) % n;
	endfunction

	// one opcode from the range of the given class
	function automatic logic [5:0] pick_opcode(input int cls);
		int r;
		case (cls)
			0: return 6'd0;
			1: return 6'(8 + rand_below(8));
			2: return 6'(32 + rand_below(6));
			3: return 6'(40 + rand_below(4));
			4: begin
				r = rand_below(5);
				return (r == 0) ? 6'd1 : 6'(r + 3);
			end
			default: begin
				r = rand_below(4);
				if (r == 0) begin
					return 6'(2 + rand_below(2));
				end
				// gap between loads and stores
				if (r == 3) begin
					return 6'(38 + rand_below(2));
				end
				return (r == 1) ? 6'(16 + rand_below(16)) : 6'(44 + rand_below(20));
			end
		endcase
	endfunction

	function automatic logic [31:0] lane_addr(input logic [31:0] pc, input int k);
		return pc - (pc % 32'(GROUP_BYTES)) + 32'(4 * k);
	endfunction

	// reference decode straight from the bit fields
	function automatic fetch_pkg::decode_info_t model_decode(input logic [31:0] w);
		fetch_pkg::decode_info_t d;
		logic [5:0] op;
		logic writes;
		op = w[31:26];
		d = '0;
		writes = 1'b0;
		d.src_a = w[25:21];
		d.src_b = w[20:16];
		d.imm = {{16{w[15]}}, w[15:0]};
		if (op == 6'd0) begin
			d.inst_class = fetch_pkg::CLASS_ALU_REG;
			d.dest = w[15:11];
			d.imm = '0;
			writes = 1'b1;
		end else if (op >= 6'd8 && op <= 6'd15) begin
			d.inst_class = fetch_pkg::CLASS_ALU_IMM;
			d.dest = w[20:16];
			writes = 1'b1;
		end else if (op >= 6'd32 && op <= 6'd37) begin
			d.inst_class = fetch_pkg::CLASS_LOAD;
			d.dest = w[20:16];
			writes = 1'b1;
		end else if (op >= 6'd40 && op <= 6'd43) begin
			d.inst_class = fetch_pkg::CLASS_STORE;
		end else if (op == 6'd1 || (op >= 6'd4 && op <= 6'd7)) begin
			d.inst_class = fetch_pkg::CLASS_BRANCH;
			d.is_ctrl = 1'b1;
		end else begin
			d.inst_class = fetch_pkg::CLASS_OTHER;
		end
		d.has_dest = writes && (d.dest != 5'd0);
		return d;
	endfunction

	task automatic check_val(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("error %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic fill_memory();
		logic [31:0] w;
		for (int i = 0; i < 256; i++) begin
			w = $random(seed);
			w[31:26] = pick_opcode(i % 6);
			// some words with rt and rd both zero, in every class
			if (i % 7 == 3) begin
				w[20:11] = '0;
			end
			mem[i] = w;
		end
	endtask

	// answers each accepted read 1 to 4 cycles later
	task automatic drive_response();
		bus_resp_valid = 1'b0;
		if (accept_seen != accept_count) begin
			accept_seen = accept_count;
			resp_wait = 1 + rand_below(4);
		end
		if (resp_wait > 0) begin
			resp_wait--;
			if (resp_wait == 0) begin
				bus_resp_valid = 1'b1;
				bus_resp_data = mem[resp_addr[9:2]];
			end
		end
	endtask

	task automatic drive_stimulus();
		bus_req_ready = (rand_below(4) != 0);
		flush = (rand_below(40) == 0);
		if (stall_left > 0) begin
			out_ready = 1'b0;
			stall_left--;
		end else if (rand_below(8) == 0) begin
			out_ready = 1'b0;
			stall_left = rand_below(6);
		end else begin
			out_ready = 1'b1;
		end
		if (taken >= NUM_GROUPS) begin
			fetch_valid = 1'b0;
			flush = 1'b0;
		end else if (!fetch_valid || taken != taken_seen) begin
			// a group offered but not taken stays as it is
			taken_seen = taken;
			fetch_valid = (rand_below(8) != 0);
			fetch_pc = $random(seed);
			fetch_mask = FETCH_SIZE'(rand_below(1 << FETCH_SIZE));
			fetch_tag = TAG_WIDTH'(tag_seq);
			tag_seq++;
		end
	endtask

	task automatic watch_bus();
		if (bus_resp_valid) begin
			resp_count++;
		end
		if (bus_req_valid && bus_req_ready) begin
			if (accept_count != resp_count) begin
				$display("bus read accepted while another read is outstanding");
				errors++;
			end
			if (exp_addr_q.size() == 0) begin
				$display("bus request at %h with no lane left to read", bus_req_addr);
				errors++;
			end else begin
				check_val("bus_req_addr_o", 64'(exp_addr_q.pop_front()), 64'(bus_req_addr));
			end
			accept_count++;
			resp_addr = bus_req_addr;
		end
	endtask

	task automatic watch_output();
		logic [31:0] pc;
		logic [31:0] addr;
		logic [FETCH_SIZE-1:0] mask;
		fetch_pkg::decode_info_t exp_dec;
		if (out_valid && out_ready) begin
			if (exp_pc_q.size() == 0) begin
				$display("output with tag %h appeared but no group was expected", out_tag);
				errors++;
			end else begin
				pc = exp_pc_q.pop_front();
				mask = exp_mask_q.pop_front();
				check_val("out_tag_o", 64'(exp_tag_q.pop_front()), 64'(out_tag));
				check_val("out_pc_o", 64'(pc), 64'(out_pc));
				check_val("out_mask_o", 64'(mask), 64'(out_mask));
				for (int k = 0; k < FETCH_SIZE; k++) begin
					exp_dec = '0;
					if (mask[k]) begin
						addr = lane_addr(pc, k);
						exp_dec = model_decode(mem[addr[9:2]]);
					end
					check_val($sformatf("out_decode_o[%0d]", k), 64'(exp_dec),
						64'(out_decode[k]));
				end
				checked++;
			end
		end
	endtask

	task automatic watch_fetch();
		if (fetch_valid && fetch_ready) begin
			exp_pc_q.push_back(fetch_pc);
			exp_mask_q.push_back(fetch_mask);
			exp_tag_q.push_back(fetch_tag);
			for (int k = 0; k < FETCH_SIZE; k++) begin
				if (fetch_mask[k]) begin
					exp_addr_q.push_back(lane_addr(fetch_pc, k));
				end
			end
			taken++;
		end
	endtask

	task automatic drop_in_flight();
		flushed += exp_pc_q.size();
		exp_pc_q.delete();
		exp_mask_q.delete();
		exp_tag_q.delete();
		exp_addr_q.delete();
	endtask

	initial begin
		seed = 32'h1f6c;
		rst_n = 1'b0;
		flush = 1'b0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fetch_mask = '0;
		fetch_tag = '0;
		out_ready = 1'b0;
		bus_req_ready = 1'b0;
		bus_resp_valid = 1'b0;
		bus_resp_data = '0;
		fill_memory();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		forever begin
			@(negedge clk);
			drive_response();
			drive_stimulus();
		end
	end

	// bus first, so a read taken on a flush edge is still checked
	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			watch_bus();
			watch_output();
			watch_fetch();
			if (flush) begin
				drop_in_flight();
			end
			if (cycles >= CYCLE_LIMIT) begin
				$display("timeout: run not finished after %0d cycles, %0d groups pending",
					cycles, exp_pc_q.size());
				$display("TEST RESULT: FAIL");
				$finish;
			end else if (taken == NUM_GROUPS && exp_pc_q.size() == 0 &&
				accept_count == resp_count) begin
				$display("checked %0d outputs, flushed %0d groups, %0d errors",
					checked, flushed, errors);
				if (errors == 0) begin
					$display("TEST RESULT: PASS");
				end else begin
					$display("TEST RESULT: FAIL");
				end
				$finish;
			end
		end
	end

endmodule
